// ==== alu_taylor.f ====
+incdir+verilog
verilog/alu_taylor_pkg.sv
verilog/taylor_term_if.sv
verilog/alu_taylor_seq.sv
verilog/alu_taylor_power.sv
verilog/alu_taylor_coefs.sv
verilog/alu_taylor_mac.sv
verilog/alu_taylor_top.sv
bench/alu_taylor_properties.sv
bench/alu_taylor_tb.sv

// ==== Bender.yml ====
package:
  name: alu_taylor

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/alu_taylor_pkg.sv
      - verilog/taylor_term_if.sv
      - verilog/alu_taylor_seq.sv
      - verilog/alu_taylor_power.sv
      - verilog/alu_taylor_coefs.sv
      - verilog/alu_taylor_mac.sv
      - verilog/alu_taylor_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - bench/alu_taylor_properties.sv
      - bench/alu_taylor_tb.sv

// ==== bench/alu_taylor_tb.sv ====
// testbench for the taylor function unit; runs req/ack requests and checks results against real math
`timescale 1ns/100ps
`include "alu_taylor_consts.svh"

module alu_taylor_tb
    import alu_taylor_pkg::*;
();

    // allowed distance from the real-valued model, 2^-8
    localparam real tol = 1.0 / 256.0;
    // cycles any single wait may take
    localparam int wait_limit = 40;

    logic      clk;
    logic      rst_n;
    logic      req;
    alu_func_t function_sel;
    fixed_t    operand;
    logic      ack;
    fixed_t    result;
    integer    seed;

    alu_taylor_top alu_taylor_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .function_sel (function_sel),
        .operand      (operand),
        .ack          (ack),
        .result       (result)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // reference model and failure reporting
    // ------------------------------------------------------------
    function automatic real to_real(input fixed_t v);
        return real'(v) / (2.0 ** `ALU_FRAC_W);
    endfunction

    function automatic real model_value(input alu_func_t f, input real x);
        case (f)
            FUNC_SIN:          return $sin(x);
            FUNC_COS:          return $cos(x);
            FUNC_INV_1_PLUS_X: return 1.0 / (1.0 + x);
            default:           return 0.0;
        endcase
    endfunction

    task automatic fail_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input real expected, input real actual);
        $display("FAIL time=%0t signal=%s expected=%0.6f actual=%0.6f",
                 $time, name, expected, actual);
        fail_run();
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s", wait_limit, what);
        fail_run();
    endtask

    // handshake checks from the bound module stop the run at once
    always @(negedge clk) begin
        if (alu_taylor_inst.props_inst.fail_count != 0) begin
            $display("a handshake assertion on the DUT failed");
            fail_run();
        end
    end

    // ------------------------------------------------------------
    // client side of the handshake
    // ------------------------------------------------------------
    task automatic wait_for_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) report_timeout(what);
        end
    endtask

    // one full four-phase cycle, req kept up extra_hold cycles past ack
    task automatic run_request(input alu_func_t f, input fixed_t x, input int extra_hold,
                               output fixed_t got);
        @(negedge clk);
        req          = 1'b1;
        function_sel = f;
        operand      = x;
        wait_for_ack(1'b1, "ack to rise");
        got = result;
        repeat (extra_hold) begin
            @(negedge clk);
            assert (ack === 1'b1) else report_mismatch("ack", 1.0, 0.0);
            assert (result === got) else report_mismatch("result", to_real(got), to_real(result));
        end
        @(negedge clk);
        req = 1'b0;
        wait_for_ack(1'b0, "ack to fall");
    endtask

    task automatic check_function(input alu_func_t f, input fixed_t x, input int extra_hold);
        fixed_t got;
        real    expected;
        run_request(f, x, extra_hold, got);
        expected = model_value(f, to_real(x));
        assert ((to_real(got) - expected <= tol) && (expected - to_real(got) <= tol))
            else report_mismatch("result", expected, to_real(got));
    endtask

    // |x| <= 1 for sin and cos, |x| <= 0.5 for 1/(1+x)
    task automatic random_operand(input alu_func_t f, output fixed_t x);
        if (f == FUNC_INV_1_PLUS_X) begin
            x = fixed_t'($random(seed) % 32769);
        end else begin
            x = fixed_t'($random(seed) % 65537);
        end
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    fixed_t trig_points[5] = '{18'sd0, 18'sd32768, -18'sd32768, 18'sd65536, -18'sd65536};
    fixed_t inv_points[5]  = '{18'sd0, 18'sd16384, -18'sd16384, 18'sd32768, -18'sd32768};
    alu_func_t alt_funcs[4] = '{FUNC_SIN, FUNC_COS, FUNC_INV_1_PLUS_X, FUNC_NONE};

    initial begin
        fixed_t    x;
        fixed_t    got;
        alu_func_t f;
        int        hold;
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = 1'b0;
        function_sel = FUNC_SIN;
        operand      = '0;
        seed         = 28784;

        // reset for 5 cycles, ack must stay low
        repeat (5) @(posedge clk);
        @(negedge clk);
        assert (ack === 1'b0) else report_mismatch("ack", 0.0, 1.0);
        rst_n = 1'b1;
        // idle, no req so no ack
        repeat (5) begin
            @(negedge clk);
            assert (ack === 1'b0) else report_mismatch("ack", 0.0, 1.0);
        end

        // sin and cos on fixed points then random ones
        for (int i = 0; i < 5; i++) check_function(FUNC_SIN, trig_points[i], 0);
        for (int i = 0; i < 20; i++) begin
            random_operand(FUNC_SIN, x);
            check_function(FUNC_SIN, x, 0);
        end
        for (int i = 0; i < 5; i++) check_function(FUNC_COS, trig_points[i], 0);
        for (int i = 0; i < 20; i++) begin
            random_operand(FUNC_COS, x);
            check_function(FUNC_COS, x, 0);
        end
        // cos(0) lands exactly on 1.0
        run_request(FUNC_COS, '0, 0, got);
        assert (got === fixed_t'(`ALU_ONE)) else report_mismatch("result", 1.0, to_real(got));

        // 1/(1+x)
        for (int i = 0; i < 5; i++) check_function(FUNC_INV_1_PLUS_X, inv_points[i], 0);
        for (int i = 0; i < 20; i++) begin
            random_operand(FUNC_INV_1_PLUS_X, x);
            check_function(FUNC_INV_1_PLUS_X, x, 0);
        end

        // unknown code right after a nonzero result
        check_function(FUNC_COS, 18'sd32768, 0);
        run_request(FUNC_NONE, 18'sd32768, 0, got);
        assert (got === '0) else report_mismatch("result", 0.0, to_real(got));

        // slow client, req held 0 to 10 cycles past ack
        for (int i = 0; i < 8; i++) begin
            f    = alt_funcs[i % 3];
            hold = $unsigned($random(seed)) % 11;
            random_operand(f, x);
            check_function(f, x, hold);
        end

        // back to back on alternating functions
        for (int i = 0; i < 12; i++) begin
            f = alt_funcs[i % 4];
            random_operand(f, x);
            check_function(f, x, 0);
        end

        repeat (3) @(negedge clk);
        if (alu_taylor_inst.props_inst.fail_count != 0) begin
            fail_run();
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== bench/alu_taylor_properties.sv ====
// req/ack handshake checks on the taylor unit top level; attached to alu_taylor_top with bind
`timescale 1ns/100ps

module alu_taylor_properties
    import alu_taylor_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   req,
    input logic   ack,
    input fixed_t result
);

    // assertion failures seen so far
    int unsigned fail_count = 0;

    // ------------------------------------------------------------
    // reset
    // ------------------------------------------------------------

    // every reset edge clears ack
    ack_low_in_reset: assert property (@(posedge clk) !rst_n |=> !ack)
        else begin fail_count++; $error("ack not cleared by reset"); end

    // first cycle out of reset
    ack_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !ack)
        else begin fail_count++; $error("ack high right after reset"); end

    // ------------------------------------------------------------
    // four-phase handshake
    // ------------------------------------------------------------

    // ack was set on the previous edge while req was up
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else begin fail_count++; $error("ack rose without req"); end

    // held for as long as the client keeps req up
    ack_held_while_req: assert property (@(posedge clk) disable iff (!rst_n)
        ack && req |=> ack)
        else begin fail_count++; $error("ack dropped while req high"); end

    // result frozen for the whole ack phase
    result_stable_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $stable(result))
        else begin fail_count++; $error("result moved while ack high"); end

    // release side of the handshake
    ack_falls_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(req) |-> ##[0:2] !ack)
        else begin fail_count++; $error("ack still high two cycles after req fell"); end

endmodule

bind alu_taylor_top alu_taylor_properties props_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (req),
    .ack    (ack),
    .result (result)
);

// ==== verilog/alu_taylor_top.sv ====
// taylor series function unit top; client side req/ack with function select, operand and result
`timescale 1ns/100ps

module alu_taylor_top
    import alu_taylor_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // four-phase request from the client
    input  logic      req,
    input  alu_func_t function_sel,
    input  fixed_t    operand,
    // result valid while ack is high
    output logic      ack,
    output fixed_t    result
);

    // ------------------------------------------------------------
    // stage links
    // ------------------------------------------------------------

    // sequencer to power stage, power field left idle
    taylor_term_if seq_term ();
    // power stage to mac
    taylor_term_if pow_term ();

    // mac tells the sequencer the result is in place
    logic done;

    // ------------------------------------------------------------
    // pipeline
    // ------------------------------------------------------------

    // handshake and index generation
    alu_taylor_seq seq_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .function_sel (function_sel),
        .operand      (operand),
        .done         (done),
        .ack          (ack),
        .term         (seq_term.source)
    );

    // running power x^n
    alu_taylor_power power_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_term  (seq_term.sink),
        .out_term (pow_term.source)
    );

    // coefficient multiply, sum and saturation
    alu_taylor_mac mac_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .term   (pow_term.sink),
        .done   (done),
        .result (result)
    );

endmodule

// ==== verilog/alu_taylor_mac.sv ====
// last pipeline stage; weights each power by its coefficient, sums the series and holds the result
`timescale 1ns/100ps
`include "alu_taylor_consts.svh"

module alu_taylor_mac
    import alu_taylor_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    taylor_term_if.sink term,
    output logic        done,
    output fixed_t      result
);

    // Q1.16 limits in accumulator format
    localparam acc_t sat_max = acc_t'((1 <<< (`ALU_FIXED_W - 1)) - 1);
    localparam acc_t sat_min = acc_t'(-(1 <<< (`ALU_FIXED_W - 1)));

    fixed_t coef;
    // Q2.32 product and the same scaled back to 16 fraction bits
    logic signed [2*`ALU_FIXED_W-1:0] prod;
    logic signed [2*`ALU_FIXED_W-1:0] prod_shr;
    acc_t   term_val;
    acc_t   acc;
    // last term went into acc on the previous edge
    logic   last_q;
    fixed_t sat_val;

    alu_taylor_coefs coefs_inst (
        .function_sel (term.func),
        .idx          (term.idx),
        .deriv_coef   (coef)
    );

    // ------------------------------------------------------------
    // product of power and coefficient
    // ------------------------------------------------------------
    assign prod     = term.power * coef;
    assign prod_shr = prod >>> `ALU_FRAC_W;
    // sign is already extended inside prod_shr, low bits are enough
    assign term_val = prod_shr[`ALU_ACC_W-1:0];

    // ------------------------------------------------------------
    // accumulator
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (term.valid) begin
            // term 0 starts a fresh sum
            if (term.idx == '0) begin
                acc <= term_val;
            end else begin
                acc <= acc + term_val;
            end
        end
    end

    // clamp to the Q1.16 range, only hit outside the specified operands
    always_comb begin
        if (acc > sat_max) begin
            sat_val = sat_max[`ALU_FIXED_W-1:0];
        end else if (acc < sat_min) begin
            sat_val = sat_min[`ALU_FIXED_W-1:0];
        end else begin
            sat_val = acc[`ALU_FIXED_W-1:0];
        end
    end

    // ------------------------------------------------------------
    // result register and done pulse
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_q <= 1'b0;
            done   <= 1'b0;
            result <= '0;
        end else begin
            last_q <= term.valid & term.last;
            done   <= last_q;
            // result only moves once per request, held for the handshake
            if (last_q) begin
                result <= sat_val;
            end
        end
    end

endmodule

// ==== verilog/alu_taylor_coefs.sv ====
// series coefficient lookup for the mac stage; f^(n)(0)/n! as a Q1.16 value from function and term
`timescale 1ns/100ps
`include "alu_taylor_consts.svh"

module alu_taylor_coefs
    import alu_taylor_pkg::*;
(
    input  alu_func_t function_sel,
    input  idx_t      idx,
    output fixed_t    deriv_coef
);

    // derivative at zero, only -1, 0 or +1 for these functions
    logic signed [1:0] deriv;
    // 1/n! in Q1.16
    fixed_t            inv_fact;
    // magnitude applied to the derivative
    fixed_t            mag;

    // ------------------------------------------------------------
    // derivative pattern, period four in n
    // ------------------------------------------------------------
    always_comb begin
        case (function_sel)
            FUNC_SIN: begin
                // 0, +1, 0, -1
                case (idx[1:0])
                    2'd1:    deriv = 2'sd1;
                    2'd3:    deriv = -2'sd1;
                    default: deriv = 2'sd0;
                endcase
            end
            FUNC_COS: begin
                // +1, 0, -1, 0
                case (idx[1:0])
                    2'd0:    deriv = 2'sd1;
                    2'd2:    deriv = -2'sd1;
                    default: deriv = 2'sd0;
                endcase
            end
            FUNC_INV_1_PLUS_X: begin
                // (-1)^n, factorial cancels out
                deriv = idx[0] ? -2'sd1 : 2'sd1;
            end
            default: deriv = 2'sd0;
        endcase
    end

    // ------------------------------------------------------------
    // inverse factorial table
    // ------------------------------------------------------------
    always_comb begin
        case (idx)
            4'd0:    inv_fact = 18'h10000;
            4'd1:    inv_fact = 18'h10000;
            4'd2:    inv_fact = 18'h08000;
            4'd3:    inv_fact = 18'h02AAB;
            4'd4:    inv_fact = 18'h00AAB;
            4'd5:    inv_fact = 18'h00222;
            4'd6:    inv_fact = 18'h0005B;
            4'd7:    inv_fact = 18'h0000D;
            4'd8:    inv_fact = 18'h00002;
            // 1/9! and beyond round to zero at 16 fraction bits
            default: inv_fact = 18'h00000;
        endcase
    end

    // only sin and cos need the factorial scaling
    assign mag = (function_sel == FUNC_INV_1_PLUS_X) ? fixed_t'(`ALU_ONE) : inv_fact;

    // apply sign, -1.0 still fits the format
    always_comb begin
        case (deriv)
            2'sd1:   deriv_coef = mag;
            -2'sd1:  deriv_coef = -mag;
            default: deriv_coef = '0;
        endcase
    end

endmodule

// ==== verilog/alu_taylor_power.sv ====
// second pipeline stage; builds x^n one multiply per beat and passes the term on a cycle later
`timescale 1ns/100ps
`include "alu_taylor_consts.svh"

module alu_taylor_power
    import alu_taylor_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    taylor_term_if.sink   in_term,
    taylor_term_if.source out_term
);

    logic      valid_q;
    alu_func_t func_q;
    idx_t      idx_q;
    logic      last_q;
    fixed_t    operand_q;
    // x^(n-1) from the previous beat
    fixed_t    pow_q;

    // Q2.32 product of previous power and x
    logic signed [2*`ALU_FIXED_W-1:0] prod;
    fixed_t                           pow_next;

    assign prod = pow_q * in_term.operand;

    // term 0 restarts the chain at 1.0, later terms drop the low fraction bits
    assign pow_next = (in_term.idx == '0) ? fixed_t'(`ALU_ONE)
                                          : prod[`ALU_FRAC_W +: `ALU_FIXED_W];

    // ------------------------------------------------------------
    // beat valid
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_term.valid;
        end
    end

    // ------------------------------------------------------------
    // payload, one cycle through
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (in_term.valid) begin
            func_q    <= in_term.func;
            idx_q     <= in_term.idx;
            last_q    <= in_term.last;
            operand_q <= in_term.operand;
            pow_q     <= pow_next;
        end
    end

    assign out_term.valid   = valid_q;
    assign out_term.func    = func_q;
    assign out_term.idx     = idx_q;
    assign out_term.last    = last_q;
    assign out_term.operand = operand_q;
    assign out_term.power   = pow_q;

endmodule

// ==== verilog/alu_taylor_seq.sv ====
// first pipeline stage; owns the client req/ack handshake and streams term indices into the pipe
`timescale 1ns/100ps
`include "alu_taylor_consts.svh"

module alu_taylor_seq
    import alu_taylor_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          req,
    input  alu_func_t     function_sel,
    input  fixed_t        operand,
    input  logic          done,
    output logic          ack,
    taylor_term_if.source term
);

    // ------------------------------------------------------------
    // last index lookup
    // ------------------------------------------------------------

    // unknown code gets a single beat so the mac restarts at zero
    function automatic idx_t last_idx_of(input alu_func_t f);
        idx_t last_idx;
        case (f)
            FUNC_SIN:          last_idx = `ALU_LAST_SIN;
            FUNC_COS:          last_idx = `ALU_LAST_COS;
            FUNC_INV_1_PLUS_X: last_idx = `ALU_LAST_INV;
            default:           last_idx = '0;
        endcase
        return last_idx;
    endfunction

    seq_state_t state;
    logic       valid_q;
    alu_func_t  func_q;
    fixed_t     operand_q;
    idx_t       idx_q;
    idx_t       last_idx_q;
    logic       last_q;
    idx_t       idx_next;

    assign idx_next = idx_q + 1'b1;

    // ------------------------------------------------------------
    // handshake FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= IDLE;
            ack     <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    // first beat goes out in the cycle after req is seen
                    if (req) begin
                        valid_q <= 1'b1;
                        state   <= ISSUE;
                    end
                end
                ISSUE: begin
                    // stop once the flagged beat has been on the bus
                    if (last_q) begin
                        valid_q <= 1'b0;
                        state   <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    // result is registered in the mac by now
                    if (done) begin
                        ack   <= 1'b1;
                        state <= HOLD_ACK;
                    end
                end
                HOLD_ACK: begin
                    // ack held as long as the client keeps req up
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // beat payload
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            // capture the request, start at term 0
            func_q     <= function_sel;
            operand_q  <= operand;
            last_idx_q <= last_idx_of(function_sel);
            idx_q      <= '0;
            last_q     <= (last_idx_of(function_sel) == '0);
        end else if (state == ISSUE && !last_q) begin
            idx_q  <= idx_next;
            last_q <= (idx_next == last_idx_q);
        end
    end

    assign term.valid   = valid_q;
    assign term.func    = func_q;
    assign term.idx     = idx_q;
    assign term.last    = last_q;
    assign term.operand = operand_q;
    // powers are formed downstream
    assign term.power   = '0;

endmodule

// ==== verilog/taylor_term_if.sv ====
// one series term per beat between pipeline stages; the upstream stage takes source, downstream sink
`timescale 1ns/100ps

interface taylor_term_if
    import alu_taylor_pkg::*;
();

    // single cycle beat marker, no ready since every stage takes a beat per cycle
    logic      valid;
    // function the term belongs to
    alu_func_t func;
    // term number n
    idx_t      idx;
    // set on the final term of a request
    logic      last;
    // x as latched from the client
    fixed_t    operand;
    // x^n, only meaningful after the power stage
    fixed_t    power;

    // upstream stage drives the whole beat
    modport source (
        output valid, func, idx, last, operand, power
    );

    // downstream stage only looks
    modport sink (
        input valid, func, idx, last, operand, power
    );

endinterface

// ==== verilog/alu_taylor_pkg.sv ====
// types shared by the taylor unit stages; import into any module or interface that uses them
`include "alu_taylor_consts.svh"

package alu_taylor_pkg;

    // signed Q1.16 value, sign bit, one integer bit, 16 fraction bits
    typedef logic signed [`ALU_FIXED_W-1:0] fixed_t;

    // running sum, same fraction bits as fixed_t
    typedef logic signed [`ALU_ACC_W-1:0] acc_t;

    // series term number, 0 is the constant term
    typedef logic [`ALU_IDX_W-1:0] idx_t;

    // function codes as seen on function_sel
    typedef enum logic [1:0] {
        FUNC_SIN,
        FUNC_COS,
        FUNC_INV_1_PLUS_X,
        // unused code, result is zero
        FUNC_NONE
    } alu_func_t;

    // sequencer FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DONE,
        HOLD_ACK
    } seq_state_t;

endpackage

// ==== verilog/alu_taylor_consts.svh ====
// widths, fixed point constants and series lengths; include wherever the taylor unit needs them
`ifndef ALU_TAYLOR_CONSTS_SVH
`define ALU_TAYLOR_CONSTS_SVH

// ------------------------------------------------------------
// number format
// ------------------------------------------------------------

// operand, power, coefficient and result width, Q1.16
`define ALU_FIXED_W 18
// fraction bits of every fixed point value
`define ALU_FRAC_W 16
// accumulator width, headroom for the sum of up to 12 terms
`define ALU_ACC_W 24
// term index width
`define ALU_IDX_W 4
// 1.0 in Q1.16
`define ALU_ONE 18'h10000

// ------------------------------------------------------------
// last term index per function
// ------------------------------------------------------------
`define ALU_LAST_SIN 4'd11
`define ALU_LAST_COS 4'd10
`define ALU_LAST_INV 4'd11

`endif
